//--- include/accel_config.svh
`ifndef ACCEL_CONFIG_SVH
`define ACCEL_CONFIG_SVH

////////////////////////////////////////////////////////////
// Datapath widths

`define ACCEL_DATA_W        32
`define ACCEL_ADDR_W        16
`define ACCEL_PIX_W         8
`define ACCEL_PSUM_W        20
`define ACCEL_SHIFT_W       4
`define ACCEL_APB_ADDR_W    8

// Pointwise convolution shape
`define ACCEL_NUM_CH        3
`define ACCEL_NUM_KN        4

////////////////////////////////////////////////////////////
// Register byte offsets

`define ACCEL_REG_CTRL      8'h00
`define ACCEL_REG_STATUS    8'h04
`define ACCEL_REG_NUM_PIX   8'h08
`define ACCEL_REG_IN_BASE   8'h0C
`define ACCEL_REG_OUT_BASE  8'h10
`define ACCEL_REG_SHIFT     8'h14
`define ACCEL_REG_WEIGHT_K0 8'h18
`define ACCEL_REG_WEIGHT_K1 8'h1C
`define ACCEL_REG_WEIGHT_K2 8'h20
`define ACCEL_REG_WEIGHT_K3 8'h24

`endif

//--- logic/accel_pkg.sv
`include "accel_config.svh"

package accel_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath types

    // Channel 0 sits in the lowest byte
    typedef logic [`ACCEL_NUM_CH-1:0][`ACCEL_PIX_W-1:0] pixel_t;

    typedef logic signed [`ACCEL_PIX_W-1:0] weight_t;

    // One weight per channel, channel 0 lowest
    typedef weight_t [`ACCEL_NUM_CH-1:0] kernel_t;

    typedef logic signed [`ACCEL_PSUM_W-1:0] psum_t;

    typedef logic [`ACCEL_PIX_W-1:0] result_t;

    typedef logic [`ACCEL_ADDR_W-1:0] mem_addr_t;

    ////////////////////////////////////////////////////////////
    // Control

    typedef enum logic {
        FETCH_IDLE,
        FETCH_RUN
    } fetch_state_e;

endpackage

//--- logic/regmap_pkg.sv
`include "accel_config.svh"

package regmap_pkg;

    // Byte offsets on the APB side
    typedef enum logic [`ACCEL_APB_ADDR_W-1:0] {
        REG_CTRL      = `ACCEL_REG_CTRL,
        REG_STATUS    = `ACCEL_REG_STATUS,
        REG_NUM_PIX   = `ACCEL_REG_NUM_PIX,
        REG_IN_BASE   = `ACCEL_REG_IN_BASE,
        REG_OUT_BASE  = `ACCEL_REG_OUT_BASE,
        REG_SHIFT     = `ACCEL_REG_SHIFT,
        REG_WEIGHT_K0 = `ACCEL_REG_WEIGHT_K0,
        REG_WEIGHT_K1 = `ACCEL_REG_WEIGHT_K1,
        REG_WEIGHT_K2 = `ACCEL_REG_WEIGHT_K2,
        REG_WEIGHT_K3 = `ACCEL_REG_WEIGHT_K3
    } reg_addr_e;

    // CTRL is write-only
    localparam int CTRL_START_BIT  = 0;

    // STATUS is read-only
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

//--- logic/config_regfile.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module config_regfile import accel_pkg::*, regmap_pkg::*; (
    input  logic                         clk,
    input  logic                         i_arst_n,

    input  logic                         i_psel,
    input  logic                         i_penable,
    input  logic                         i_pwrite,
    input  logic [`ACCEL_APB_ADDR_W-1:0] i_paddr,
    input  logic [`ACCEL_DATA_W-1:0]     i_pwdata,
    output logic [`ACCEL_DATA_W-1:0]     o_prdata,
    output logic                         o_pready,
    output logic                         o_pslverr,

    input  logic                         i_done,
    output logic                         o_start,
    output logic [`ACCEL_DATA_W-1:0]     o_num_pix,
    output mem_addr_t                    o_in_base,
    output mem_addr_t                    o_out_base,
    output logic [`ACCEL_SHIFT_W-1:0]    o_shift,
    output kernel_t                      o_weights [`ACCEL_NUM_KN]
);

    logic access;
    logic addr_ok;
    logic wr_en;
    logic cfg_wr;
    logic start_req;
    logic busy_q;
    logic done_q;

    // Zero wait states, every transfer ends in its access phase
    assign access    = i_psel && i_penable;
    assign wr_en     = access && i_pwrite && addr_ok;
    assign cfg_wr    = wr_en && !busy_q;
    assign start_req = cfg_wr && (i_paddr == REG_CTRL) && i_pwdata[CTRL_START_BIT];

    assign o_pready  = 1'b1;
    assign o_pslverr = access && !addr_ok;

    ////////////////////////////////////////////////////////////
    // Address decode and read mux

    always_comb begin
        addr_ok  = 1'b1;
        o_prdata = '0;
        case (i_paddr)
            // Start reads back as zero
            REG_CTRL:      o_prdata = '0;
            REG_STATUS: begin
                o_prdata[STATUS_BUSY_BIT] = busy_q;
                o_prdata[STATUS_DONE_BIT] = done_q;
            end
            REG_NUM_PIX:   o_prdata = o_num_pix;
            REG_IN_BASE:   o_prdata = `ACCEL_DATA_W'(o_in_base);
            REG_OUT_BASE:  o_prdata = `ACCEL_DATA_W'(o_out_base);
            REG_SHIFT:     o_prdata = `ACCEL_DATA_W'(o_shift);
            REG_WEIGHT_K0: o_prdata = `ACCEL_DATA_W'(o_weights[0]);
            REG_WEIGHT_K1: o_prdata = `ACCEL_DATA_W'(o_weights[1]);
            REG_WEIGHT_K2: o_prdata = `ACCEL_DATA_W'(o_weights[2]);
            REG_WEIGHT_K3: o_prdata = `ACCEL_DATA_W'(o_weights[3]);
            default:       addr_ok  = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Configuration registers, frozen while busy

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_num_pix  <= '0;
            o_in_base  <= '0;
            o_out_base <= '0;
            o_shift    <= '0;
            for (int k = 0; k < `ACCEL_NUM_KN; k++) begin
                o_weights[k] <= '0;
            end
        end else if (cfg_wr) begin
            case (i_paddr)
                REG_NUM_PIX:   o_num_pix    <= i_pwdata;
                REG_IN_BASE:   o_in_base    <= i_pwdata[`ACCEL_ADDR_W-1:0];
                REG_OUT_BASE:  o_out_base   <= i_pwdata[`ACCEL_ADDR_W-1:0];
                REG_SHIFT:     o_shift      <= i_pwdata[`ACCEL_SHIFT_W-1:0];
                REG_WEIGHT_K0: o_weights[0] <= i_pwdata[$bits(kernel_t)-1:0];
                REG_WEIGHT_K1: o_weights[1] <= i_pwdata[$bits(kernel_t)-1:0];
                REG_WEIGHT_K2: o_weights[2] <= i_pwdata[$bits(kernel_t)-1:0];
                REG_WEIGHT_K3: o_weights[3] <= i_pwdata[$bits(kernel_t)-1:0];
                default: ;
            endcase
        end
    end

    // Busy from start until the last output write
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_start <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            o_start <= start_req;
            if (start_req) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (i_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

endmodule

//--- logic/pixel_fetch.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module pixel_fetch import accel_pkg::*; (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_start,
    input  logic                     i_stall,
    input  logic [`ACCEL_DATA_W-1:0] i_num_pix,
    input  mem_addr_t                i_in_base,
    output mem_addr_t                o_in_addr,
    output logic                     o_in_rden,
    output logic                     o_word_vld
);

    fetch_state_e             state_q;
    logic [`ACCEL_DATA_W-1:0] words_left_q;
    logic                     issue;

    // One read per cycle unless unpack is full
    assign issue     = (state_q == FETCH_RUN) && !i_stall;
    assign o_in_rden = issue;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q      <= FETCH_IDLE;
            words_left_q <= '0;
            o_in_addr    <= '0;
            o_word_vld   <= 1'b0;
        end else begin
            // Read data shows up one cycle after the enable
            o_word_vld <= issue;
            case (state_q)
                FETCH_IDLE: begin
                    if (i_start) begin
                        // Four pixels pack into three words
                        words_left_q <= (i_num_pix >> 2) * `ACCEL_NUM_CH;
                        o_in_addr    <= i_in_base;
                        state_q      <= FETCH_RUN;
                    end
                end
                FETCH_RUN: begin
                    if (issue) begin
                        o_in_addr    <= o_in_addr + 1'b1;
                        words_left_q <= words_left_q - 1'b1;
                        if (words_left_q == 1) begin
                            state_q <= FETCH_IDLE;
                        end
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

endmodule

//--- logic/pixel_unpack.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module pixel_unpack import accel_pkg::*; (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic [`ACCEL_DATA_W-1:0] i_word,
    input  logic                     i_word_vld,
    output logic                     o_stall,
    output pixel_t                   o_pix,
    output logic                     o_pix_vld
);

    localparam int WORD_BYTES = `ACCEL_DATA_W / 8;
    localparam int PIX_BYTES  = `ACCEL_NUM_CH;
    localparam int BUF_BYTES  = 3 * WORD_BYTES;
    localparam int BUF_W      = BUF_BYTES * 8;
    localparam int CNT_W      = $clog2(BUF_BYTES + 1);

    // Stall threshold leaves room for the word in flight plus one more
    localparam int STALL_LVL  = BUF_BYTES - 2 * WORD_BYTES;

    logic [BUF_W-1:0] bytes_q;
    logic [BUF_W-1:0] bytes_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_keep;
    logic [CNT_W-1:0] cnt_d;

    assign o_pix_vld = (cnt_q >= CNT_W'(PIX_BYTES));
    assign o_pix     = bytes_q[$bits(pixel_t)-1:0];
    assign o_stall   = (cnt_q > CNT_W'(STALL_LVL));

    ////////////////////////////////////////////////////////////
    // Pop one pixel, then append the new word above what is left

    always_comb begin
        bytes_d  = o_pix_vld ? (bytes_q >> $bits(pixel_t)) : bytes_q;
        cnt_keep = o_pix_vld ? (cnt_q - CNT_W'(PIX_BYTES)) : cnt_q;
        cnt_d    = cnt_keep;
        if (i_word_vld) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                bytes_d[(cnt_keep + i) * 8 +: 8] = i_word[i * 8 +: 8];
            end
            cnt_d = cnt_keep + CNT_W'(WORD_BYTES);
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // Bytes above the fill count are don't care
    always_ff @(posedge clk) begin
        bytes_q <= bytes_d;
    end

endmodule

//--- logic/kc_mac.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module kc_mac import accel_pkg::*; (
    input  logic    clk,
    input  logic    i_arst_n,
    input  pixel_t  i_pix,
    input  logic    i_pix_vld,
    input  kernel_t i_weights [`ACCEL_NUM_KN],
    output psum_t   o_psum [`ACCEL_NUM_KN],
    output logic    o_psum_vld
);

    // Unsigned byte times signed byte
    localparam int PROD_W = 2 * `ACCEL_PIX_W + 1;

    typedef logic signed [PROD_W-1:0] prod_t;

    prod_t prod_q [`ACCEL_NUM_KN][`ACCEL_NUM_CH];
    psum_t sum_d  [`ACCEL_NUM_KN];
    logic  prod_vld_q;

    ////////////////////////////////////////////////////////////
    // Stage one, kernel by channel products

    always_ff @(posedge clk) begin
        if (i_pix_vld) begin
            for (int k = 0; k < `ACCEL_NUM_KN; k++) begin
                for (int c = 0; c < `ACCEL_NUM_CH; c++) begin
                    prod_q[k][c] <= $signed({1'b0, i_pix[c]}) * i_weights[k][c];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage two, sum over channels

    always_comb begin
        for (int k = 0; k < `ACCEL_NUM_KN; k++) begin
            sum_d[k] = '0;
            for (int c = 0; c < `ACCEL_NUM_CH; c++) begin
                sum_d[k] = sum_d[k] + psum_t'(prod_q[k][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_vld_q) begin
            o_psum <= sum_d;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            prod_vld_q <= 1'b0;
            o_psum_vld <= 1'b0;
        end else begin
            prod_vld_q <= i_pix_vld;
            o_psum_vld <= prod_vld_q;
        end
    end

endmodule

//--- logic/output_writer.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module output_writer import accel_pkg::*; (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  psum_t                     i_psum [`ACCEL_NUM_KN],
    input  logic                      i_psum_vld,
    input  logic [`ACCEL_DATA_W-1:0]  i_num_pix,
    input  mem_addr_t                 i_out_base,
    input  logic [`ACCEL_SHIFT_W-1:0] i_shift,
    output mem_addr_t                 o_out_addr,
    output logic [`ACCEL_DATA_W-1:0]  o_out_wdata,
    output logic                      o_out_wren,
    output logic                      o_done
);

    localparam psum_t RES_MAX = psum_t'(2 ** `ACCEL_PIX_W - 1);

    logic [`ACCEL_DATA_W-1:0] word_cnt_q;
    logic [`ACCEL_DATA_W-1:0] wdata_d;
    logic                     last;

    // ReLU, arithmetic shift, saturate to one byte
    function automatic result_t quantize(psum_t sum, logic [`ACCEL_SHIFT_W-1:0] shamt);
        psum_t shifted;
        shifted = sum >>> shamt;
        if (sum < 0) begin
            return '0;
        end
        if (shifted > RES_MAX) begin
            return '1;
        end
        return result_t'(shifted);
    endfunction

    always_comb begin
        for (int k = 0; k < `ACCEL_NUM_KN; k++) begin
            wdata_d[k * `ACCEL_PIX_W +: `ACCEL_PIX_W] = quantize(i_psum[k], i_shift);
        end
    end

    assign last = (word_cnt_q == i_num_pix - 1'b1);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_out_wren <= 1'b0;
            o_done     <= 1'b0;
            word_cnt_q <= '0;
        end else begin
            o_out_wren <= i_psum_vld;
            o_done     <= i_psum_vld && last;
            if (i_psum_vld) begin
                word_cnt_q <= last ? '0 : word_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_psum_vld) begin
            o_out_wdata <= wdata_d;
            o_out_addr  <= i_out_base + word_cnt_q[`ACCEL_ADDR_W-1:0];
        end
    end

endmodule

//--- logic/dnn_accel_top.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module dnn_accel_top import accel_pkg::*; (
    input  logic                         clk,
    input  logic                         i_arst_n,

    // APB host port
    input  logic                         i_psel,
    input  logic                         i_penable,
    input  logic                         i_pwrite,
    input  logic [`ACCEL_APB_ADDR_W-1:0] i_paddr,
    input  logic [`ACCEL_DATA_W-1:0]     i_pwdata,
    output logic [`ACCEL_DATA_W-1:0]     o_prdata,
    output logic                         o_pready,
    output logic                         o_pslverr,

    // Input memory, one cycle read latency
    output mem_addr_t                    o_in_addr,
    output logic                         o_in_rden,
    input  logic [`ACCEL_DATA_W-1:0]     i_in_rdata,

    // Output memory
    output mem_addr_t                    o_out_addr,
    output logic [`ACCEL_DATA_W-1:0]     o_out_wdata,
    output logic                         o_out_wren
);

    ////////////////////////////////////////////////////////////
    // Configuration

    logic                         start_pulse;
    logic                         done_pulse;
    logic [`ACCEL_DATA_W-1:0]     num_pix;
    mem_addr_t                    in_base;
    mem_addr_t                    out_base;
    logic [`ACCEL_SHIFT_W-1:0]    shift;
    kernel_t                      weights [`ACCEL_NUM_KN];

    config_regfile u_regfile (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .i_done     (done_pulse),
        .o_start    (start_pulse),
        .o_num_pix  (num_pix),
        .o_in_base  (in_base),
        .o_out_base (out_base),
        .o_shift    (shift),
        .o_weights  (weights)
    );

    ////////////////////////////////////////////////////////////
    // Pipeline stages

    logic                         word_vld;
    logic                         stall;
    pixel_t                       pix;
    logic                         pix_vld;
    psum_t                        psum [`ACCEL_NUM_KN];
    logic                         psum_vld;

    pixel_fetch u_fetch (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_start    (start_pulse),
        .i_stall    (stall),
        .i_num_pix  (num_pix),
        .i_in_base  (in_base),
        .o_in_addr  (o_in_addr),
        .o_in_rden  (o_in_rden),
        .o_word_vld (word_vld)
    );

    // Read data comes straight from the memory, framed by word_vld
    pixel_unpack u_unpack (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_word     (i_in_rdata),
        .i_word_vld (word_vld),
        .o_stall    (stall),
        .o_pix      (pix),
        .o_pix_vld  (pix_vld)
    );

    kc_mac u_mac (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_pix      (pix),
        .i_pix_vld  (pix_vld),
        .i_weights  (weights),
        .o_psum     (psum),
        .o_psum_vld (psum_vld)
    );

    output_writer u_writer (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_psum      (psum),
        .i_psum_vld  (psum_vld),
        .i_num_pix   (num_pix),
        .i_out_base  (out_base),
        .i_shift     (shift),
        .o_out_addr  (o_out_addr),
        .o_out_wdata (o_out_wdata),
        .o_out_wren  (o_out_wren),
        .o_done      (done_pulse)
    );

endmodule

//--- tb/tb_dnn_accel.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module tb_dnn_accel import accel_pkg::*, regmap_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_RUNS   = 8;
    // Run 5 saturates both ways and runs 6 and 7 go back to back
    localparam int SAT_RUN    = 5;
    localparam int MEM_WORDS  = 1 << `ACCEL_ADDR_W;

    logic                         clk = 1'b0;
    logic                         i_arst_n;
    logic                         i_psel;
    logic                         i_penable;
    logic                         i_pwrite;
    logic [`ACCEL_APB_ADDR_W-1:0] i_paddr;
    logic [`ACCEL_DATA_W-1:0]     i_pwdata;
    logic [`ACCEL_DATA_W-1:0]     o_prdata;
    logic                         o_pready;
    logic                         o_pslverr;
    mem_addr_t                    o_in_addr;
    logic                         o_in_rden;
    logic [`ACCEL_DATA_W-1:0]     i_in_rdata = '0;
    mem_addr_t                    o_out_addr;
    logic [`ACCEL_DATA_W-1:0]     o_out_wdata;
    logic                         o_out_wren;

    integer      seed;
    int unsigned watchdog_cycles = 0;
    logic [31:0] in_mem [MEM_WORDS];
    logic [31:0] out_mem [MEM_WORDS];
    bit          out_written [MEM_WORDS];
    logic        rd_pending = 1'b0;
    mem_addr_t   rd_addr = '0;
    mem_addr_t   cur_out_base = '0;
    int          cur_num_pix = 0;

    // Per-run settings drawn before reset
    int          run_num_pix [NUM_RUNS];
    mem_addr_t   run_in_base [NUM_RUNS];
    mem_addr_t   run_out_base [NUM_RUNS];
    logic [3:0]  run_shift [NUM_RUNS];
    kernel_t     run_wts [NUM_RUNS][`ACCEL_NUM_KN];

    always #(CLK_PERIOD / 2) clk = ~clk;

    dnn_accel_top dut_i (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .o_in_addr   (o_in_addr),
        .o_in_rden   (o_in_rden),
        .i_in_rdata  (i_in_rdata),
        .o_out_addr  (o_out_addr),
        .o_out_wdata (o_out_wdata),
        .o_out_wren  (o_out_wren)
    );

    ////////////////////////////////////////////////////////////
    // Checks

    task automatic report_failure();
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_result(input mem_addr_t addr, input int k, input result_t got,
                                input result_t exp);
        if (got !== exp) begin
            $display("MISMATCH o_out_wdata byte %0d at 0x%04h: got 0x%02h expected 0x%02h",
                     k, addr, got, exp);
            report_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB host with setup and access phases

    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                              input logic exp_err, output logic [31:0] rdata);
        logic err;
        logic ready;
        @(negedge clk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge clk);
        i_penable = 1'b1;
        // Mid access phase, well clear of the edge
        #(CLK_PERIOD / 4);
        err   = o_pslverr;
        ready = o_pready;
        rdata = o_prdata;
        @(negedge clk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        check_reg("o_pready", 32'(ready), 32'd1);
        check_reg("o_pslverr", 32'(err), 32'(exp_err));
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
        apb_access(1'b0, addr, '0, exp_err, data);
    endtask

    task automatic wait_done(output logic [31:0] status);
        do begin
            apb_read(REG_STATUS, status, 1'b0);
        end while (status[STATUS_DONE_BIT] == 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model

    // Implemented bits of each config register
    function automatic logic [31:0] reg_mask(input logic [7:0] addr);
        case (addr)
            REG_NUM_PIX:              return 32'hFFFF_FFFF;
            REG_IN_BASE, REG_OUT_BASE: return 32'h0000_FFFF;
            REG_SHIFT:                return 32'h0000_000F;
            default:                  return 32'h00FF_FFFF;
        endcase
    endfunction

    // Little endian byte stream with three bytes per pixel
    function automatic pixel_t get_pixel(input mem_addr_t base, input int idx);
        pixel_t      pix;
        int          b;
        logic [31:0] w;
        for (int c = 0; c < `ACCEL_NUM_CH; c++) begin
            b      = 3 * idx + c;
            w      = in_mem[mem_addr_t'(base + b / 4)];
            pix[c] = w[(b % 4) * 8 +: 8];
        end
        return pix;
    endfunction

    function automatic result_t model_byte(input pixel_t pix, input kernel_t wts,
                                           input logic [3:0] shamt);
        int sum;
        sum = 0;
        for (int c = 0; c < `ACCEL_NUM_CH; c++) begin
            sum += int'(pix[c]) * int'(wts[c]);
        end
        if (sum < 0) begin
            return 8'h00;
        end
        sum = sum >>> shamt;
        if (sum > 255) begin
            return 8'hFF;
        end
        return result_t'(sum);
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory models

    // Data for a read arrives in the following cycle
    always @(negedge clk) begin
        i_in_rdata <= rd_pending ? in_mem[rd_addr] : '0;
        rd_pending <= o_in_rden;
        rd_addr    <= o_in_addr;
    end

    always @(negedge clk) begin
        mem_addr_t ofs;
        if (o_out_wren) begin
            ofs = o_out_addr - cur_out_base;
            if (int'(ofs) >= cur_num_pix) begin
                $display("ERROR: output write to 0x%04h lies outside the run's range", o_out_addr);
                report_failure();
            end
            if (out_written[o_out_addr]) begin
                $display("ERROR: output address 0x%04h written twice", o_out_addr);
                report_failure();
            end
            out_mem[o_out_addr]     = o_out_wdata;
            out_written[o_out_addr] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Runs

    task automatic setup_runs(output int total);
        total = 0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_num_pix[r]  = 4 * (1 + (($random(seed) & 32'h7FFF_FFFF) % 16));
            run_in_base[r]  = mem_addr_t'($random(seed) & 32'h3FFF);
            run_out_base[r] = mem_addr_t'(32'h8000 | ($random(seed) & 32'h3FFF));
            run_shift[r]    = 4'($random(seed));
            for (int k = 0; k < `ACCEL_NUM_KN; k++) begin
                run_wts[r][k] = kernel_t'(24'($random(seed)));
            end
            if (r == SAT_RUN) begin
                run_num_pix[r] = 32;
                run_shift[r]   = 4'd0;
                run_wts[r][0]  = kernel_t'(24'h808080);
                run_wts[r][1]  = kernel_t'(24'h7F7F7F);
            end
            total += run_num_pix[r];
        end
        // Second of the back to back pair reads its own region
        run_in_base[NUM_RUNS-1] = run_in_base[NUM_RUNS-2] + 16'h1000;
    endtask

    task automatic run_conv(input int r);
        logic [31:0] rd;
        logic [31:0] word;
        logic [3:0]  other_shift;
        mem_addr_t   oa;
        pixel_t      pix;
        int          n_words;
        n_words = run_num_pix[r] / 4 * 3;
        for (int w = 0; w < n_words; w++) begin
            word = $random(seed);
            if (r == SAT_RUN) begin
                word = word | 32'h0101_0101;
            end
            in_mem[run_in_base[r] + mem_addr_t'(w)] = word;
        end
        for (int i = 0; i < run_num_pix[r]; i++) begin
            out_written[run_out_base[r] + mem_addr_t'(i)] = 1'b0;
        end
        cur_out_base = run_out_base[r];
        cur_num_pix  = run_num_pix[r];

        apb_write(REG_NUM_PIX, 32'(run_num_pix[r]), 1'b0);
        apb_write(REG_IN_BASE, 32'(run_in_base[r]), 1'b0);
        apb_write(REG_OUT_BASE, 32'(run_out_base[r]), 1'b0);
        apb_write(REG_SHIFT, 32'(run_shift[r]), 1'b0);
        for (int k = 0; k < `ACCEL_NUM_KN; k++) begin
            apb_write(8'(REG_WEIGHT_K0) + 8'(4 * k), 32'(run_wts[r][k]), 1'b0);
        end
        apb_write(REG_CTRL, 32'd1 << CTRL_START_BIT, 1'b0);

        apb_read(REG_STATUS, rd, 1'b0);
        check_reg("REG_STATUS", rd, 32'd1 << STATUS_BUSY_BIT);
        if (r == SAT_RUN) begin
            // Config is frozen while the engine runs
            other_shift = ~run_shift[r];
            apb_write(REG_SHIFT, 32'(other_shift), 1'b0);
            apb_read(REG_SHIFT, rd, 1'b0);
            check_reg("REG_SHIFT", rd, 32'(run_shift[r]));
        end
        wait_done(rd);
        check_reg("REG_STATUS", rd, 32'd1 << STATUS_DONE_BIT);

        // Start was written, yet CTRL still reads as zero
        apb_read(REG_CTRL, rd, 1'b0);
        check_reg("REG_CTRL", rd, '0);

        for (int i = 0; i < run_num_pix[r]; i++) begin
            oa = run_out_base[r] + mem_addr_t'(i);
            if (!out_written[oa]) begin
                $display("ERROR: no output write reached address 0x%04h", oa);
                report_failure();
            end
            pix = get_pixel(run_in_base[r], i);
            for (int k = 0; k < `ACCEL_NUM_KN; k++) begin
                check_result(oa, k, out_mem[oa][k * 8 +: 8],
                             model_byte(pix, run_wts[r][k], run_shift[r]));
            end
            if (r == SAT_RUN) begin
                check_result(oa, 0, out_mem[oa][7:0], 8'h00);
                check_result(oa, 1, out_mem[oa][15:8], 8'hFF);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
        report_failure();
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] wval;
        logic [31:0] shadow [8];
        logic [7:0]  addr;
        int          total_pix;
        seed      = 19108;
        i_arst_n  = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        setup_runs(total_pix);
        watchdog_cycles = 100 * total_pix + 2000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;

        apb_read(REG_STATUS, rd, 1'b0);
        check_reg("REG_STATUS", rd, '0);
        apb_read(REG_CTRL, rd, 1'b0);
        check_reg("REG_CTRL", rd, '0);

        // Config registers from NUM_PIX up to the last weight
        for (int i = 0; i < 8; i++) begin
            addr      = 8'(REG_NUM_PIX) + 8'(4 * i);
            wval      = $random(seed);
            shadow[i] = wval & reg_mask(addr);
            apb_write(addr, wval, 1'b0);
            apb_read(addr, rd, 1'b0);
            check_reg($sformatf("reg 0x%02h", addr), rd, shadow[i]);
        end

        // Unmapped offset errors and changes nothing
        apb_write(8'h40, 32'hFFFF_FFFF, 1'b1);
        apb_read(8'h40, rd, 1'b1);
        for (int i = 0; i < 8; i++) begin
            addr = 8'(REG_NUM_PIX) + 8'(4 * i);
            apb_read(addr, rd, 1'b0);
            check_reg($sformatf("reg 0x%02h", addr), rd, shadow[i]);
        end

        for (int r = 0; r < NUM_RUNS; r++) begin
            run_conv(r);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- dnn_accel_top.f
+incdir+include
logic/accel_pkg.sv
logic/regmap_pkg.sv
logic/config_regfile.sv
logic/pixel_fetch.sv
logic/pixel_unpack.sv
logic/kc_mac.sv
logic/output_writer.sv
logic/dnn_accel_top.sv
tb/tb_dnn_accel.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run the testbench; exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f dnn_accel_top.f --top-module tb_dnn_accel -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
